/* logic/branch_predictor.sv */
module branch_predictor #(
   parameter int bht_index_w = 6
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [fetch_pkg::pc_w-1:0] pc,
   input  fetch_pkg::slot_mask_t      brnch_mask,
   input  logic                       update_bpred,
   input  logic                       resolve_valid,
   input  logic [fetch_pkg::pc_w-1:0] resolve_pc,
   input  logic                       resolve_taken,
   output fetch_pkg::pred_pair_t      pred_to_pcsel
);
   import fetch_pkg::*;

   localparam int bht_size = 1 << bht_index_w;

   // two-bit saturating counters
   logic [1:0] bht [bht_size];

   // global history, newest vote in the lsb
   logic [bht_index_w-1:0] ghr;

   logic [pc_w-1:0]        addr_first;
   logic [pc_w-1:0]        addr_second;
   logic [2:0]             seen;
   logic [bht_index_w-1:0] idx_first;
   logic [bht_index_w-1:0] idx_second;
   logic [bht_index_w-1:0] idx_train;

   ////////////////////////////////////////////////////////////
   // lookup for the first two branches of the group
   ////////////////////////////////////////////////////////////

   always_comb begin
      addr_first  = pc;
      addr_second = pc;
      seen        = '0;
      for (int i = 0; i < group_n; i++) begin
         if (brnch_mask[group_n-1-i]) begin
            if (seen == 3'd0) begin
               addr_first = pc + pc_w'(i);
            end else if (seen == 3'd1) begin
               addr_second = pc + pc_w'(i);
            end
            seen = seen + 1'b1;
         end
      end
   end

   // same hash for lookup and training
   assign idx_first  = addr_first[bht_index_w-1:0] ^ ghr;
   assign idx_second = addr_second[bht_index_w-1:0] ^ ghr;
   assign idx_train  = resolve_pc[bht_index_w-1:0] ^ ghr;

   // vote is the counter msb
   assign pred_to_pcsel = {bht[idx_first][1], bht[idx_second][1]};

   // training from resolve, saturating both ways
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         // weakly not taken
         for (int i = 0; i < bht_size; i++) begin
            bht[i] <= 2'b01;
         end
      end else if (resolve_valid) begin
         if (resolve_taken && (bht[idx_train] != 2'b11)) begin
            bht[idx_train] <= bht[idx_train] + 1'b1;
         end else if (!resolve_taken && (bht[idx_train] != 2'b00)) begin
            bht[idx_train] <= bht[idx_train] - 1'b1;
         end
      end
   end

   // shift in the first-branch vote
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ghr <= '0;
      end else if (update_bpred) begin
         ghr <= {ghr[bht_index_w-2:0], pred_to_pcsel[1]};
      end
   end

   // filter only asks for an update when the group holds a branch
   a_update_has_branch: assert property (@(posedge clk) disable iff (!rst_n)
      update_bpred |-> (|brnch_mask));

endmodule

/* logic/fetch_front_end.sv */
module fetch_front_end #(
   parameter int mem_depth_log2 = 10,
   parameter int bht_index_w    = 6
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       load_we,
   input  logic [mem_depth_log2-1:0]  load_addr,
   input  isa_pkg::inst_word_u        load_data,
   input  logic                       stall_for_jump,
   input  logic                       decr_count,
   input  logic                       mispred_num,
   input  logic                       resolve_valid,
   input  logic [fetch_pkg::pc_w-1:0] resolve_pc,
   input  logic                       resolve_taken,
   output isa_pkg::inst_word_u        instruction0,
   output isa_pkg::inst_word_u        instruction1,
   output isa_pkg::inst_word_u        instruction2,
   output isa_pkg::inst_word_u        instruction3,
   output logic [fetch_pkg::pc_w-1:0] pc,
   output logic                       brch_full,
   output fetch_pkg::slot_mask_t      tkn_mask
);
   import isa_pkg::*;
   import fetch_pkg::*;

   // memory port
   logic [mem_depth_log2-1:0] mem_addr;
   logic                      mem_we;
   inst_word_u                mem_wdata;
   logic                      fetch_stall;

   // raw group
   inst_word_u inst0;
   inst_word_u inst1;
   inst_word_u inst2;
   inst_word_u inst3;

   // filter to predictor and sequencer
   slot_mask_t      brnch_mask;
   slot_mask_t      imm_jmp_mask;
   pred_pair_t      pred_to_pcsel;
   logic            update_bpred;
   logic            pcsel_hold;
   logic [pc_w-1:0] pc_seq;

   ////////////////////////////////////////////////////////////
   // shared instruction memory
   ////////////////////////////////////////////////////////////

   imem_arbiter #(
      .mem_depth_log2(mem_depth_log2)
   ) u_imem_arbiter (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_we    (load_we),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .fetch_pc   (pc),
      .mem_addr   (mem_addr),
      .mem_we     (mem_we),
      .mem_wdata  (mem_wdata),
      .fetch_stall(fetch_stall)
   );

   inst_mem #(
      .mem_depth_log2(mem_depth_log2)
   ) u_inst_mem (
      .clk  (clk),
      .we   (mem_we),
      .addr (mem_addr),
      .wdata(mem_wdata),
      .inst0(inst0),
      .inst1(inst1),
      .inst2(inst2),
      .inst3(inst3)
   );

   ////////////////////////////////////////////////////////////
   // prediction, filtering, next pc
   ////////////////////////////////////////////////////////////

   branch_predictor #(
      .bht_index_w(bht_index_w)
   ) u_branch_predictor (
      .clk          (clk),
      .rst_n        (rst_n),
      .pc           (pc),
      .brnch_mask   (brnch_mask),
      .update_bpred (update_bpred),
      .resolve_valid(resolve_valid),
      .resolve_pc   (resolve_pc),
      .resolve_taken(resolve_taken),
      .pred_to_pcsel(pred_to_pcsel)
   );

   group_filter u_group_filter (
      .clk           (clk),
      .rst_n         (rst_n),
      .pc            (pc),
      .inst0         (inst0),
      .inst1         (inst1),
      .inst2         (inst2),
      .inst3         (inst3),
      .stall_for_jump(stall_for_jump),
      .stall_fetch   (fetch_stall),
      .pred_to_pcsel (pred_to_pcsel),
      .decr_count    (decr_count),
      .mispred_num   (mispred_num),
      .update_bpred  (update_bpred),
      .brnch_mask    (brnch_mask),
      .imm_jmp_mask  (imm_jmp_mask),
      .tkn_mask      (tkn_mask),
      .pcsel_hold    (pcsel_hold),
      .pc_seq        (pc_seq),
      .instruction0  (instruction0),
      .instruction1  (instruction1),
      .instruction2  (instruction2),
      .instruction3  (instruction3),
      .brch_full     (brch_full)
   );

   // loads reach the sequencer through the filter hold
   pc_sequencer u_pc_sequencer (
      .clk         (clk),
      .rst_n       (rst_n),
      .pcsel_hold  (pcsel_hold),
      .pc_seq      (pc_seq),
      .tkn_mask    (tkn_mask),
      .imm_jmp_mask(imm_jmp_mask),
      .instruction0(instruction0),
      .instruction1(instruction1),
      .instruction2(instruction2),
      .instruction3(instruction3),
      .pc          (pc)
   );

endmodule

/* logic/fetch_pkg.sv */
package fetch_pkg;

   ////////////////////////////////////////////////////////////
   // fetch geometry
   ////////////////////////////////////////////////////////////

   // program counter width, word addressed
   localparam int pc_w = 16;

   // slots fetched per cycle
   localparam int group_n = 4;

   // unresolved branch count
   typedef logic [1:0] bcnt_t;

   // at most two branches in flight
   localparam bcnt_t max_inflight = 2'd2;

   // one bit per slot, msb is slot 0 (oldest)
   typedef logic [group_n-1:0] slot_mask_t;

   // bit 1 votes for the first branch, bit 0 for the second
   typedef logic [1:0] pred_pair_t;

endpackage

/* logic/group_filter.sv */
module group_filter (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [fetch_pkg::pc_w-1:0] pc,
   input  isa_pkg::inst_word_u        inst0,
   input  isa_pkg::inst_word_u        inst1,
   input  isa_pkg::inst_word_u        inst2,
   input  isa_pkg::inst_word_u        inst3,
   input  logic                       stall_for_jump,
   input  logic                       stall_fetch,
   input  fetch_pkg::pred_pair_t      pred_to_pcsel,
   input  logic                       decr_count,
   input  logic                       mispred_num,
   output logic                       update_bpred,
   output fetch_pkg::slot_mask_t      brnch_mask,
   output fetch_pkg::slot_mask_t      imm_jmp_mask,
   output fetch_pkg::slot_mask_t      tkn_mask,
   output logic                       pcsel_hold,
   output logic [fetch_pkg::pc_w-1:0] pc_seq,
   output isa_pkg::inst_word_u        instruction0,
   output isa_pkg::inst_word_u        instruction1,
   output isa_pkg::inst_word_u        instruction2,
   output isa_pkg::inst_word_u        instruction3,
   output logic                       brch_full
);
   import isa_pkg::*;
   import fetch_pkg::*;

   // slot-ordered views, index 0 is the oldest
   inst_word_u         slot [group_n];
   logic [group_n-1:0] is_br;
   logic [group_n-1:0] is_jmp;
   logic [group_n-1:0] is_imm;
   logic [group_n-1:0] third_hit;
   logic [group_n-1:0] nop;
   logic [group_n-1:0] taken;

   logic       stall;
   logic       hold;
   logic       block;
   logic [2:0] ord;
   bcnt_t      bcnt;
   bcnt_t      incr;
   bcnt_t      dec;
   bcnt_t      bcnt_nxt;
   logic [2:0] sum;

   assign slot[0] = inst0;
   assign slot[1] = inst1;
   assign slot[2] = inst2;
   assign slot[3] = inst3;

   // both stalls kill the whole group
   assign stall = stall_fetch || stall_for_jump;

   ////////////////////////////////////////////////////////////
   // per-slot decode
   ////////////////////////////////////////////////////////////

   always_comb begin
      for (int i = 0; i < group_n; i++) begin
         is_br[i]  = (slot[i].br.cls == cls_branch) && (slot[i].br.cond != 2'b00);
         is_jmp[i] = (slot[i].jmp.opcode == op_jump);
         is_imm[i] = is_jmp[i] && (slot[i].jmp.mode == 2'b00);
      end
   end

   ////////////////////////////////////////////////////////////
   // no-op chain, oldest slot first
   ////////////////////////////////////////////////////////////

   always_comb begin
      block = stall || hold;
      // raw branches seen before this slot
      ord   = '0;
      incr  = '0;
      for (int i = 0; i < group_n; i++) begin
         // in-flight plus earlier group branches already at the cap
         third_hit[i] = !block && is_br[i] && (({1'b0, bcnt} + ord) >= 3'(max_inflight));
         nop[i]       = block || third_hit[i];
         // first branch takes vote bit 1, second takes bit 0
         taken[i]     = !nop[i] && is_br[i] &&
                        ((ord == 3'd0) ? pred_to_pcsel[1] :
                         (ord == 3'd1) ? pred_to_pcsel[0] : 1'b0);
         if (!nop[i] && is_br[i]) begin
            incr = incr + 1'b1;
         end
         if (is_br[i]) begin
            ord = ord + 1'b1;
         end
         // everything younger dies
         block = nop[i] || is_jmp[i] || taken[i];
      end
   end

   // slot-ordered vectors onto msb-first masks
   always_comb begin
      for (int i = 0; i < group_n; i++) begin
         brnch_mask[group_n-1-i]   = is_br[i];
         imm_jmp_mask[group_n-1-i] = is_imm[i] && !nop[i];
         tkn_mask[group_n-1-i]     = taken[i];
      end
   end

   assign update_bpred = |(is_br & ~nop);

   ////////////////////////////////////////////////////////////
   // in-flight branch count and hold
   ////////////////////////////////////////////////////////////

   // retire removes one, two on a misprediction
   assign dec = decr_count ? (mispred_num ? 2'd2 : 2'd1) : 2'd0;
   assign sum = {1'b0, bcnt} + {1'b0, incr};

   always_comb begin
      if (sum <= {1'b0, dec}) begin
         bcnt_nxt = '0;
      end else if ((sum - {1'b0, dec}) > {1'b0, max_inflight}) begin
         bcnt_nxt = max_inflight;
      end else begin
         bcnt_nxt = bcnt_t'(sum - {1'b0, dec});
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bcnt <= '0;
      end else begin
         bcnt <= bcnt_nxt;
      end
   end

   // third branch parks fetch until a retire
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hold <= 1'b0;
      end else if (decr_count) begin
         hold <= 1'b0;
      end else if (|third_hit) begin
         hold <= 1'b1;
      end
   end

   assign brch_full = hold;

   ////////////////////////////////////////////////////////////
   // next pc hint and filtered words
   ////////////////////////////////////////////////////////////

   assign pcsel_hold = stall || hold || (|third_hit);

   // restart at the third branch, else fall through
   always_comb begin
      pc_seq = pc + pc_w'(group_n);
      for (int i = group_n - 1; i >= 0; i--) begin
         if (third_hit[i]) begin
            pc_seq = pc + pc_w'(i);
         end
      end
      // register jump in slot 0 waits here
      if (stall || hold || is_jmp[0]) begin
         pc_seq = pc;
      end
   end

   assign instruction0 = nop[0] ? nop_word : inst0;
   assign instruction1 = nop[1] ? nop_word : inst1;
   assign instruction2 = nop[2] ? nop_word : inst2;
   assign instruction3 = nop[3] ? nop_word : inst3;

   a_count_cap: assert property (@(posedge clk) disable iff (!rst_n)
      bcnt <= max_inflight);

   // a killed slot kills every younger slot
   a_nop_tail: assert property (@(posedge clk) disable iff (!rst_n)
      ((nop << 1) & ~nop) == '0);

endmodule

/* logic/imem_arbiter.sv */
module imem_arbiter #(
   parameter int mem_depth_log2 = 10
) (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         load_we,
   input  logic [mem_depth_log2-1:0]    load_addr,
   input  isa_pkg::inst_word_u          load_data,
   input  logic [fetch_pkg::pc_w-1:0]   fetch_pc,
   output logic [mem_depth_log2-1:0]    mem_addr,
   output logic                         mem_we,
   output isa_pkg::inst_word_u          mem_wdata,
   output logic                         fetch_stall
);

   // port owner encoding
   localparam logic own_fetch = 1'b0;
   localparam logic own_load  = 1'b1;

   logic grant;
   logic owner_q;

   // loader always wins
   assign grant = load_we ? own_load : own_fetch;

   assign mem_addr    = (grant == own_load) ? load_addr : fetch_pc[mem_depth_log2-1:0];
   assign mem_we      = (grant == own_load);
   assign mem_wdata   = load_data;
   // fetch loses only this cycle
   assign fetch_stall = (grant == own_load);

   // owner of the previous cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         owner_q <= own_fetch;
      end else begin
         owner_q <= grant;
      end
   end

   // pc frozen across a load cycle
   a_load_holds_pc: assert property (@(posedge clk) disable iff (!rst_n)
      (owner_q == own_load) |-> (fetch_pc == $past(fetch_pc)));

endmodule

/* logic/inst_mem.sv */
module inst_mem #(
   parameter int mem_depth_log2 = 10
) (
   input  logic                      clk,
   input  logic                      we,
   input  logic [mem_depth_log2-1:0] addr,
   input  isa_pkg::inst_word_u       wdata,
   output isa_pkg::inst_word_u       inst0,
   output isa_pkg::inst_word_u       inst1,
   output isa_pkg::inst_word_u       inst2,
   output isa_pkg::inst_word_u       inst3
);
   import isa_pkg::*;

   localparam int depth = 1 << mem_depth_log2;

   // program storage
   inst_word_u mem [depth];

   // neighbour addresses, wrap at the top of the array
   logic [mem_depth_log2-1:0] addr1;
   logic [mem_depth_log2-1:0] addr2;
   logic [mem_depth_log2-1:0] addr3;

   assign addr1 = addr + 1'b1;
   assign addr2 = addr + 2'd2;
   assign addr3 = addr + 2'd3;

   // one word per cycle from the loader
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
   end

   ////////////////////////////////////////////////////////////
   // group read, four words, no clock
   ////////////////////////////////////////////////////////////

   // slot 0 is the word at the pc
   assign inst0 = mem[addr];
   assign inst1 = mem[addr1];
   assign inst2 = mem[addr2];
   assign inst3 = mem[addr3];

endmodule

/* logic/isa_pkg.sv */
package isa_pkg;

   ////////////////////////////////////////////////////////////
   // instruction word, 16 bits, two decode views
   ////////////////////////////////////////////////////////////

   // same bits read as a conditional branch or as a jump
   typedef union packed {
      // branch view
      struct packed {
         // 2'b10 marks a branch
         logic [1:0]         cls;
         // zero condition means not a branch
         logic [1:0]         cond;
         // pc-relative, from the slot address
         logic signed [11:0] offset;
      } br;
      // jump view
      struct packed {
         // all ones marks a jump
         logic [3:0] opcode;
         // absolute target for immediate jumps
         logic [9:0] target;
         // zero mode is the immediate form, else register jump
         logic [1:0] mode;
      } jmp;
   } inst_word_u;

   // opcode field of any jump
   localparam logic [3:0] op_jump = 4'hF;

   // class field of a conditional branch
   localparam logic [1:0] cls_branch = 2'b10;

   // all zeros, neither branch nor jump
   localparam logic [15:0] nop_word = 16'h0000;

endpackage

/* logic/pc_sequencer.sv */
module pc_sequencer (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       pcsel_hold,
   input  logic [fetch_pkg::pc_w-1:0] pc_seq,
   input  fetch_pkg::slot_mask_t      tkn_mask,
   input  fetch_pkg::slot_mask_t      imm_jmp_mask,
   input  isa_pkg::inst_word_u        instruction0,
   input  isa_pkg::inst_word_u        instruction1,
   input  isa_pkg::inst_word_u        instruction2,
   input  isa_pkg::inst_word_u        instruction3,
   output logic [fetch_pkg::pc_w-1:0] pc
);
   import isa_pkg::*;
   import fetch_pkg::*;

   inst_word_u      word [group_n];
   logic            br_hit;
   logic            jmp_hit;
   logic [pc_w-1:0] br_tgt;
   logic [pc_w-1:0] jmp_tgt;

   assign word[0] = instruction0;
   assign word[1] = instruction1;
   assign word[2] = instruction2;
   assign word[3] = instruction3;

   ////////////////////////////////////////////////////////////
   // redirect targets, oldest hit wins
   ////////////////////////////////////////////////////////////

   always_comb begin
      br_hit  = 1'b0;
      jmp_hit = 1'b0;
      br_tgt  = pc_seq;
      jmp_tgt = pc_seq;
      for (int i = 0; i < group_n; i++) begin
         // slot address plus sign-extended offset
         if (tkn_mask[group_n-1-i] && !br_hit) begin
            br_hit = 1'b1;
            br_tgt = pc + pc_w'(i) + pc_w'(word[i].br.offset);
         end
         // absolute target, zero-extended
         if (imm_jmp_mask[group_n-1-i] && !jmp_hit) begin
            jmp_hit = 1'b1;
            jmp_tgt = pc_w'(word[i].jmp.target);
         end
      end
   end

   // one step per edge
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= '0;
      end else if (pcsel_hold) begin
         pc <= pc_seq;
      end else if (br_hit) begin
         pc <= br_tgt;
      end else if (jmp_hit) begin
         pc <= jmp_tgt;
      end else begin
         pc <= pc_seq;
      end
   end

   // filter leaves at most one taken branch per group
   a_single_taken: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(tkn_mask));

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the fetch front end testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sources.f \
   --top-module tb_fetch_front_end -o tb_fetch_front_end > build.log 2>&1 \
   && ./obj_dir/tb_fetch_front_end > sim.log 2>&1 \
   || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -qx "=== PASS ===" sim.log && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }

/* sources.f */
logic/isa_pkg.sv
logic/fetch_pkg.sv
logic/inst_mem.sv
logic/imem_arbiter.sv
logic/branch_predictor.sv
logic/group_filter.sv
logic/pc_sequencer.sv
logic/fetch_front_end.sv
tb/tb_fetch_front_end.sv

/* tb/fetch_input.mem */
// columns: kind arg_a arg_b stall | pc inst0 inst1 inst2 inst3 brch_full tkn_mask
// kind 0 load (addr data), 1 step, 2 retire (mispred), 3 resolve (pc taken)
// program load, fetch stalled at pc 0
0 0000 1000 0 0000 0000 0000 0000 0000 0 0
0 0001 1001 0 0000 0000 0000 0000 0000 0 0
0 0002 1002 0 0000 0000 0000 0000 0000 0 0
0 0003 1003 0 0000 0000 0000 0000 0000 0 0
0 0004 1004 0 0000 0000 0000 0000 0000 0 0
0 0005 f040 0 0000 0000 0000 0000 0000 0 0
0 0010 9040 0 0000 0000 0000 0000 0000 0 0
0 0011 1011 0 0000 0000 0000 0000 0000 0 0
0 0012 1012 0 0000 0000 0000 0000 0000 0 0
0 0013 1013 0 0000 0000 0000 0000 0000 0 0
0 0014 900c 0 0000 0000 0000 0000 0000 0 0
0 0020 9010 0 0000 0000 0000 0000 0000 0 0
0 0021 1021 0 0000 0000 0000 0000 0000 0 0
0 0022 9020 0 0000 0000 0000 0000 0000 0 0
0 0023 1023 0 0000 0000 0000 0000 0000 0 0
0 0024 1024 0 0000 0000 0000 0000 0000 0 0
0 0025 9030 0 0000 0000 0000 0000 0000 0 0
0 0026 1026 0 0000 0000 0000 0000 0000 0 0
0 0027 1027 0 0000 0000 0000 0000 0000 0 0
0 0028 1028 0 0000 0000 0000 0000 0000 0 0
// train the branch at 0014 to strongly taken, history still zero
3 0014 0001 1 0000 0000 0000 0000 0000 0 0
3 0014 0001 1 0000 0000 0000 0000 0000 0 0
// straight line, then stall, then jump in slot 1 to 0010
1 0000 0000 0 0000 1000 1001 1002 1003 0 0
1 0000 0000 1 0004 0000 0000 0000 0000 0 0
1 0000 0000 0 0004 1004 f040 0000 0000 0 0
// untrained branch passes all slots, trained one redirects to 0020
1 0000 0000 0 0010 9040 1011 1012 1013 0 0
1 0000 0000 0 0014 900c 0000 0000 0000 0 8
// mispredict retire drops two, then two branches pass
2 0001 0000 1 0020 0000 0000 0000 0000 0 0
1 0000 0000 0 0020 9010 1021 9020 1023 0 0
// third branch at 0025 parks fetch until a retire
1 0000 0000 0 0024 1024 0000 0000 0000 0 0
1 0000 0000 0 0025 0000 0000 0000 0000 1 0
2 0000 0000 0 0025 0000 0000 0000 0000 1 0
1 0000 0000 0 0025 9030 1026 1027 1028 0 0

/* tb/tb_fetch_front_end.sv */
module tb_fetch_front_end;
   import isa_pkg::*;
   import fetch_pkg::*;

   localparam int mem_depth_log2 = 10;
   localparam int bht_index_w    = 6;

   // fields per record, records at most
   localparam int rec_w   = 11;
   localparam int max_rec = 64;

   // record kinds as written in the data file
   localparam logic [15:0] k_load    = 16'h0;
   localparam logic [15:0] k_step    = 16'h1;
   localparam logic [15:0] k_retire  = 16'h2;
   localparam logic [15:0] k_resolve = 16'h3;

   logic                      clk;
   logic                      rst_n;
   logic                      load_we;
   logic [mem_depth_log2-1:0] load_addr;
   inst_word_u                load_data;
   logic                      stall_for_jump;
   logic                      decr_count;
   logic                      mispred_num;
   logic                      resolve_valid;
   logic [pc_w-1:0]           resolve_pc;
   logic                      resolve_taken;
   inst_word_u                instruction0;
   inst_word_u                instruction1;
   inst_word_u                instruction2;
   inst_word_u                instruction3;
   logic [pc_w-1:0]           pc;
   logic                      brch_full;
   slot_mask_t                tkn_mask;

   // flat record store, rec_w words per record
   logic [15:0] recs [rec_w*max_rec];

   int errors       = 0;
   int failed_tests = 0;
   int n_rec        = 0;
   int cycles       = 0;
   int limit;

   fetch_front_end #(
      .mem_depth_log2(mem_depth_log2),
      .bht_index_w   (bht_index_w)
   ) dut (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_we       (load_we),
      .load_addr     (load_addr),
      .load_data     (load_data),
      .stall_for_jump(stall_for_jump),
      .decr_count    (decr_count),
      .mispred_num   (mispred_num),
      .resolve_valid (resolve_valid),
      .resolve_pc    (resolve_pc),
      .resolve_taken (resolve_taken),
      .instruction0  (instruction0),
      .instruction1  (instruction1),
      .instruction2  (instruction2),
      .instruction3  (instruction3),
      .pc            (pc),
      .brch_full     (brch_full),
      .tkn_mask      (tkn_mask)
   );

   // period 40
   always #20 clk = ~clk;

   ////////////////////////////////////////////////////////////
   // compare tasks, one per result kind
   ////////////////////////////////////////////////////////////

   task automatic check_word(input string name, input inst_word_u got, input inst_word_u exp);
      if (got !== exp) begin
         $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_pc(input string name, input logic [pc_w-1:0] got,
                           input logic [pc_w-1:0] exp);
      if (got !== exp) begin
         $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_mask(input string name, input slot_mask_t got, input slot_mask_t exp);
      if (got !== exp) begin
         $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   function automatic string kind_name(input logic [15:0] kind);
      case (kind)
         k_load:    kind_name = "load";
         k_step:    kind_name = "step";
         k_retire:  kind_name = "retire";
         k_resolve: kind_name = "resolve";
         default:   kind_name = "unknown";
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // record drive and record check
   ////////////////////////////////////////////////////////////

   task automatic apply_record(input int r);
      int b;
      b = r * rec_w;
      // pulses low unless the kind raises them
      load_we        = 1'b0;
      decr_count     = 1'b0;
      mispred_num    = 1'b0;
      resolve_valid  = 1'b0;
      resolve_taken  = 1'b0;
      stall_for_jump = recs[b+3][0];
      case (recs[b])
         k_load: begin
            load_we   = 1'b1;
            load_addr = recs[b+1][mem_depth_log2-1:0];
            load_data = recs[b+2];
         end
         k_retire: begin
            decr_count  = 1'b1;
            mispred_num = recs[b+1][0];
         end
         k_resolve: begin
            resolve_valid = 1'b1;
            resolve_pc    = recs[b+1];
            resolve_taken = recs[b+2][0];
         end
         // plain fetch cycle
         default: begin
         end
      endcase
   endtask

   task automatic check_record(input int r);
      int b;
      b = r * rec_w;
      check_pc("pc", pc, recs[b+4]);
      check_word("instruction0", instruction0, recs[b+5]);
      check_word("instruction1", instruction1, recs[b+6]);
      check_word("instruction2", instruction2, recs[b+7]);
      check_word("instruction3", instruction3, recs[b+8]);
      check_flag("brch_full", brch_full, recs[b+9][0]);
      check_mask("tkn_mask", tkn_mask, recs[b+10][group_n-1:0]);
   endtask

   // run length guard
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > limit) begin
         $display("timeout: run still going after %0d cycles", cycles);
         $display("=== FAIL ===");
         $finish;
      end
   end

   initial begin
      int errs_before;
      clk            = 1'b0;
      rst_n          = 1'b0;
      load_we        = 1'b0;
      load_addr      = '0;
      load_data      = nop_word;
      // fetch frozen until the first record
      stall_for_jump = 1'b1;
      decr_count     = 1'b0;
      mispred_num    = 1'b0;
      resolve_valid  = 1'b0;
      resolve_pc     = '0;
      resolve_taken  = 1'b0;
      // unknown kind marks the end of the records
      for (int i = 0; i < rec_w * max_rec; i++) begin
         recs[i] = 16'hffff;
      end
      $readmemh("tb/fetch_input.mem", recs);
      while ((n_rec < max_rec) && (recs[n_rec*rec_w] <= k_resolve)) begin
         n_rec++;
      end
      limit = n_rec * 2 + 20;
      repeat (3) @(posedge clk);
      #5;
      rst_n = 1'b1;
      // drive after the edge, check at the falling edge
      for (int r = 0; r < n_rec; r++) begin
         @(posedge clk);
         #5;
         apply_record(r);
         @(negedge clk);
         errs_before = errors;
         check_record(r);
         if (errors == errs_before) begin
            $display("test %0d %s: ok", r, kind_name(recs[r*rec_w]));
         end else begin
            $display("test %0d %s: %0d mismatches", r, kind_name(recs[r*rec_w]),
                     errors - errs_before);
            failed_tests++;
         end
      end
      if (n_rec == 0) begin
         $display("no test records found in tb/fetch_input.mem");
         errors++;
      end
      $display("summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
               n_rec, n_rec - failed_tests, failed_tests, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule
